// ==== verilog/corr_data_pkg.sv ====
`default_nettype none

// --------------------------------------------------------------------------
//  Antenna and pair constants for the sample side of the correlator
// --------------------------------------------------------------------------
package corr_data_pkg;

   // Sign-bit antennas feeding the correlator
   localparam int NANT = 4;

   // One pair per unordered antenna combination, NANT*(NANT-1)/2
   localparam int NPAIR = NANT * (NANT - 1) / 2;

   // Pair index width, leaves two spare codes (6 and 7)
   localparam int PAIR_BITS = 3;

   // Antenna table for each pair index
   // Order is (0,1) (0,2) (0,3) (1,2) (1,3) (2,3)
   localparam int pair_a [NPAIR] = '{0, 0, 0, 1, 1, 2};
   localparam int pair_b [NPAIR] = '{1, 2, 3, 2, 3, 3};

endpackage : corr_data_pkg

`default_nettype wire

// ==== verilog/corr_bus_pkg.sv ====
`default_nettype none

// --------------------------------------------------------------------------
//  Read-port address layout and status register codes
// --------------------------------------------------------------------------
package corr_bus_pkg;

   // Read address width, flag + pair + component
   localparam int ADDR_BITS = 5;

   // Same 5-bit word, two decodes selected by the top bit
   typedef union packed {
      struct packed {
         logic       stat;       // 0 for visibility reads
         logic [2:0] pair;       // Pair index, 6 and 7 read as zero
         logic       comp;       // 0 real, 1 imaginary
      } vis;
      struct packed {
         logic       stat;       // 1 for status reads
         logic [2:0] rsvd;       // Don't care
         logic       sel;        // Status register select
      } st;
   } rd_addr_u;

   // Status register selects
   localparam logic STAT_BANK   = 1'b0;  // Active bank in bit 0
   localparam logic STAT_FRAMES = 1'b1;  // Completed frame count

endpackage : corr_bus_pkg

`default_nettype wire

// ==== verilog/sign_hilbert.sv ====
`default_nettype none

// Crude quadrature for 1-bit samples. The imaginary stream is just the
// previous enabled sample, which is a quarter-wave shift only near fs/4,
// but good enough for sign correlation
module sign_hilbert
   import corr_data_pkg::*;
   (
   input  logic            clk_i,
   input  logic            rst_i,
   input  logic            en_i,     // data_i valid
   input  logic [NANT-1:0] data_i,   // Antenna sign bits
   output logic            valid_o,  // re_o/im_o valid
   output logic [NANT-1:0] re_o,
   output logic [NANT-1:0] im_o
   );

   logic [NANT-1:0] dly;   // Last enabled sample

   // ------------------------------------------------------------------------
   //  Control, one-cycle valid pipeline and delay line
   // ------------------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         valid_o <= 1'b0;
         dly     <= '0;     // First imaginary word comes out zero
      end else begin
         valid_o <= en_i;
         if (en_i)
            dly <= data_i;
      end
   end

   // Payload only moves on enabled samples
   always_ff @(posedge clk_i) begin
      if (en_i) begin
         re_o <= data_i;    // Current sample
         im_o <= dly;       // One sample back
      end
   end

endmodule : sign_hilbert

`default_nettype wire

// ==== verilog/frame_counter.sv ====
`default_nettype none

// Counts valid samples within a frame and flags the one that completes
// sums_i samples. The bank FSM clears the count on that same sample
module frame_counter #(
   parameter int ACCUM = 16          // Counter and frame length width
   ) (
   input  logic             clk_i,
   input  logic             rst_i,
   input  logic             valid_i, // Sample strobe from the quadrature stage
   input  logic             clr_i,   // Restart count, from the bank FSM
   input  logic [ACCUM-1:0] sums_i,  // Frame length, at least 1
   output logic             last_o   // Final sample of this frame
   );

   logic [ACCUM-1:0] count;     // Samples seen so far in this frame
   logic [ACCUM-1:0] final_cnt; // Count value of the last sample

   // Frame length must be held during a frame, so this is stable
   assign final_cnt = sums_i - {{(ACCUM-1){1'b0}}, 1'b1};

   // Combinational so the FSM sees it on the same edge as the sample
   assign last_o = valid_i && (count == final_cnt);

   // ------------------------------------------------------------------------
   //  Sample counter
   // ------------------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         count <= '0;
      end else if (valid_i) begin
         if (clr_i)
            count <= '0;                                      // New frame
         else
            count <= count + {{(ACCUM-1){1'b0}}, 1'b1};
      end
   end

endmodule : frame_counter

`default_nettype wire

// ==== verilog/bank_switch_fsm.sv ====
`default_nettype none

// Bank-switch controller. On the last sample of a frame it flips the
// active bank, strobes swap_o, and arms first-sample clearing so the new
// bank loads rather than accumulates on its next sample
module bank_switch_fsm #(
   parameter int ACCUM = 16           // Width of the frame count
   ) (
   input  logic             clk_i,
   input  logic             rst_i,
   input  logic             valid_i,  // Sample strobe
   input  logic             last_i,   // Last sample of frame
   output logic             bank_o,   // Active (write) bank
   output logic             swap_o,   // One-cycle bank-switch strobe
   output logic             first_o,  // Next sample loads accumulators
   output logic             clr_o,    // Restart the frame count
   output logic [ACCUM-1:0] frames_o  // Completed frames, wraps
   );

   // State codes
   localparam logic [1:0] S_IDLE  = 2'd0;  // Nothing seen since reset
   localparam logic [1:0] S_ACCUM = 2'd1;  // Frame filling
   localparam logic [1:0] S_FIRST = 2'd2;  // Bank just switched

   logic [1:0] state;
   logic [1:0] state_nxt;

   // ------------------------------------------------------------------------
   //  Next-state logic
   // ------------------------------------------------------------------------
   always_comb begin
      state_nxt = state;
      case (state)
         S_IDLE, S_FIRST: begin
            if (last_i)               // Single-sample frame, swap again
               state_nxt = S_FIRST;
            else if (valid_i)
               state_nxt = S_ACCUM;
         end
         S_ACCUM: begin
            if (last_i)
               state_nxt = S_FIRST;
         end
         default: state_nxt = S_IDLE;
      endcase
   end

   // Both IDLE and FIRST load, so no bank ever keeps power-up junk
   assign first_o = (state != S_ACCUM);

   // last_i already implies a valid sample
   assign clr_o = last_i;

   // ------------------------------------------------------------------------
   //  State, bank and frame-count registers
   // ------------------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state    <= S_IDLE;
         bank_o   <= 1'b0;
         swap_o   <= 1'b0;
         frames_o <= '0;
      end else begin
         state  <= state_nxt;
         swap_o <= last_i;                   // Same edge as the toggle
         if (last_i) begin
            bank_o   <= ~bank_o;             // Last sample went to old bank
            frames_o <= frames_o + {{(ACCUM-1){1'b0}}, 1'b1};
         end
      end
   end

endmodule : bank_switch_fsm

`default_nettype wire

// ==== verilog/vis_accumulator.sv ====
`default_nettype none

// Two banks of agreement counters, one real and one imaginary per pair.
// The active bank is written from the sample stream while the other
// bank is read back through a combinational lookup
module vis_accumulator
   import corr_data_pkg::*;
   #(
   parameter int ACCUM = 16                 // Counter width
   ) (
   input  logic                 clk_i,
   input  logic                 valid_i,    // Sample strobe
   input  logic                 first_i,    // Load instead of add
   input  logic                 bank_i,     // Active (write) bank
   input  logic [NANT-1:0]      re_i,       // Real sign stream
   input  logic [NANT-1:0]      im_i,       // Imaginary sign stream
   input  logic                 rd_bank_i,  // Lookup bank
   input  logic [PAIR_BITS-1:0] rd_pair_i,  // Lookup pair index
   input  logic                 rd_comp_i,  // 0 real, 1 imaginary
   output logic [ACCUM-1:0]     rd_word_o
   );

   // Accumulator storage indexed [pair][bank]
   logic [ACCUM-1:0] acc_re [NPAIR][2];
   logic [ACCUM-1:0] acc_im [NPAIR][2];

   // Per-pair agreement bits for the current sample
   logic [NPAIR-1:0] agree_re;
   logic [NPAIR-1:0] agree_im;

   // ------------------------------------------------------------------------
   //  XNOR sign products (a 1-bit multiply)
   // ------------------------------------------------------------------------
   for (genvar p = 0; p < NPAIR; p++) begin : g_pair
      assign agree_re[p] = ~(re_i[pair_a[p]] ^ re_i[pair_b[p]]);
      // Imaginary uses the quadrature of the first antenna only
      assign agree_im[p] = ~(im_i[pair_a[p]] ^ re_i[pair_b[p]]);

      // Load on the first sample into a bank and add after that
      always_ff @(posedge clk_i) begin
         if (valid_i) begin
            if (first_i) begin
               acc_re[p][bank_i] <= {{(ACCUM-1){1'b0}}, agree_re[p]};
               acc_im[p][bank_i] <= {{(ACCUM-1){1'b0}}, agree_im[p]};
            end else begin
               acc_re[p][bank_i] <= acc_re[p][bank_i]
                                    + {{(ACCUM-1){1'b0}}, agree_re[p]};
               acc_im[p][bank_i] <= acc_im[p][bank_i]
                                    + {{(ACCUM-1){1'b0}}, agree_im[p]};
            end
         end
      end
   end

   // ------------------------------------------------------------------------
   //  Read-back lookup
   // ------------------------------------------------------------------------
   always_comb begin
      rd_word_o = '0;                        // Spare pair codes read zero
      if (rd_pair_i < PAIR_BITS'(NPAIR)) begin
         if (rd_comp_i)
            rd_word_o = acc_im[rd_pair_i][rd_bank_i];
         else
            rd_word_o = acc_re[rd_pair_i][rd_bank_i];
      end
   end

endmodule : vis_accumulator

`default_nettype wire

// ==== verilog/vis_read_port.sv ====
`default_nettype none

// Single-cycle read port. Visibility reads are steered at the inactive
// bank, status reads pick the bank or frame-count register
module vis_read_port
   import corr_data_pkg::*, corr_bus_pkg::*;
   #(
   parameter int ACCUM = 16                  // Data word width
   ) (
   input  logic                 clk_i,
   input  logic                 rst_i,
   input  logic                 rd_stb_i,    // Read request
   input  logic [ADDR_BITS-1:0] rd_adr_i,
   input  logic                 bank_i,      // Active bank from the FSM
   input  logic [ACCUM-1:0]     frames_i,    // Completed frames
   input  logic [ACCUM-1:0]     vis_word_i,  // Accumulator lookup result
   output logic [PAIR_BITS-1:0] vis_pair_o,
   output logic                 vis_comp_o,
   output logic                 vis_bank_o,
   output logic [ACCUM-1:0]     rd_dat_o,    // Held until the next read
   output logic                 rd_ack_o     // Pulse, one cycle after strobe
   );

   rd_addr_u         adr;
   logic [ACCUM-1:0] word;   // Word selected this cycle

   assign adr = rd_addr_u'(rd_adr_i);

   // Lookup fields, ignored by the mux on status reads
   assign vis_pair_o = adr.vis.pair;
   assign vis_comp_o = adr.vis.comp;
   assign vis_bank_o = ~bank_i;   // Never read the bank being written

   // ------------------------------------------------------------------------
   //  Word select
   // ------------------------------------------------------------------------
   always_comb begin
      if (!adr.st.stat)
         word = vis_word_i;
      else if (adr.st.sel == STAT_BANK)
         word = {{(ACCUM-1){1'b0}}, bank_i};
      else
         word = frames_i;                    // STAT_FRAMES
   end

   always_ff @(posedge clk_i) begin
      if (rst_i)
         rd_ack_o <= 1'b0;
      else
         rd_ack_o <= rd_stb_i;
   end

   // Data register only loads on a strobe
   always_ff @(posedge clk_i) begin
      if (rd_stb_i)
         rd_dat_o <= word;
   end

endmodule : vis_read_port

`default_nettype wire

// ==== verilog/corr_top.sv ====
`default_nettype none

// Four-antenna sign correlator with two banks of visibility accumulators.
// Samples feed a quadrature stage, then six pair counters in the active
// bank; the read port only ever sees the inactive bank
module corr_top
   import corr_data_pkg::*, corr_bus_pkg::*;
   #(
   parameter int ACCUM = 16                  // Accumulator and data width
   ) (
   input  logic                 clk_i,
   input  logic                 rst_i,

   // Sample input
   input  logic                 en_i,        // data_i valid
   input  logic [NANT-1:0]      data_i,      // Antenna sign bits
   input  logic [ACCUM-1:0]     sums_i,      // Samples per frame, >= 1

   // Read port
   input  logic                 rd_stb_i,
   input  logic [ADDR_BITS-1:0] rd_adr_i,
   output logic [ACCUM-1:0]     rd_dat_o,
   output logic                 rd_ack_o,

   // Bank status
   output logic                 swap_o,      // Bank-switch strobe
   output logic                 bank_o       // Active bank
   );

   // Quadrature stage outputs
   logic            hv;
   logic [NANT-1:0] hre;
   logic [NANT-1:0] him;

   // Frame and bank control
   logic             last;
   logic             clr;
   logic             first;
   logic [ACCUM-1:0] frames;

   // Accumulator lookup
   logic [PAIR_BITS-1:0] vis_pair;
   logic                 vis_comp;
   logic                 vis_bank;
   logic [ACCUM-1:0]     vis_word;

   // ------------------------------------------------------------------------
   //  Sample path
   // ------------------------------------------------------------------------
   sign_hilbert u_hilb (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .en_i    (en_i),
      .data_i  (data_i),
      .valid_o (hv),
      .re_o    (hre),
      .im_o    (him)
   );

   frame_counter #(.ACCUM(ACCUM)) u_frame (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .valid_i (hv),
      .clr_i   (clr),
      .sums_i  (sums_i),
      .last_o  (last)
   );

   bank_switch_fsm #(.ACCUM(ACCUM)) u_bsw (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .valid_i  (hv),
      .last_i   (last),
      .bank_o   (bank_o),
      .swap_o   (swap_o),
      .first_o  (first),
      .clr_o    (clr),
      .frames_o (frames)
   );

   // ------------------------------------------------------------------------
   //  Accumulators and read-back
   // ------------------------------------------------------------------------
   vis_accumulator #(.ACCUM(ACCUM)) u_acc (
      .clk_i     (clk_i),
      .valid_i   (hv),
      .first_i   (first),
      .bank_i    (bank_o),
      .re_i      (hre),
      .im_i      (him),
      .rd_bank_i (vis_bank),
      .rd_pair_i (vis_pair),
      .rd_comp_i (vis_comp),
      .rd_word_o (vis_word)
   );

   vis_read_port #(.ACCUM(ACCUM)) u_rd (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .rd_stb_i   (rd_stb_i),
      .rd_adr_i   (rd_adr_i),
      .bank_i     (bank_o),
      .frames_i   (frames),
      .vis_word_i (vis_word),
      .vis_pair_o (vis_pair),
      .vis_comp_o (vis_comp),
      .vis_bank_o (vis_bank),
      .rd_dat_o   (rd_dat_o),
      .rd_ack_o   (rd_ack_o)
   );

endmodule : corr_top

`default_nettype wire

// ==== tests/corr_top_checker.sv ====
`default_nettype none

// Concurrent checks on the bank strobe and the read handshake
module corr_top_checker (
   input logic clk_i,
   input logic rst_i,
   input logic swap_o,
   input logic bank_o,
   input logic rd_stb_i,
   input logic rd_ack_o
   );

   timeunit 1ns;
   timeprecision 100ps;

   int fail_cnt = 0;   // Failed assertions so far

   // ------------------------------------------------------------------------
   //  Bank strobe
   // ------------------------------------------------------------------------
   a_swap_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
      swap_o |=> !swap_o)
      else begin
         $error("swap_o stayed high for two cycles");
         fail_cnt++;
      end

   // Bank flips on the same edge that raises swap_o
   a_bank_on_swap: assert property (@(posedge clk_i) disable iff (rst_i)
      $changed(bank_o) |-> swap_o)
      else begin
         $error("bank_o changed without swap_o");
         fail_cnt++;
      end

   // ------------------------------------------------------------------------
   //  Read handshake with fixed one-cycle latency
   // ------------------------------------------------------------------------
   a_ack_after_stb: assert property (@(posedge clk_i) disable iff (rst_i)
      rd_stb_i |=> rd_ack_o)
      else begin
         $error("rd_ack_o missing one cycle after rd_stb_i");
         fail_cnt++;
      end

   a_ack_only_after_stb: assert property (@(posedge clk_i) disable iff (rst_i)
      rd_ack_o |-> $past(rd_stb_i))
      else begin
         $error("rd_ack_o without a strobe in the cycle before");
         fail_cnt++;
      end

endmodule : corr_top_checker

bind corr_top corr_top_checker u_chk (
   .clk_i    (clk_i),
   .rst_i    (rst_i),
   .swap_o   (swap_o),
   .bank_o   (bank_o),
   .rd_stb_i (rd_stb_i),
   .rd_ack_o (rd_ack_o)
);

`default_nettype wire

// ==== tests/corr_top_tb.sv ====
`default_nettype none

// Frame-table testbench for the sign correlator, with a software model
module corr_top_tb
   import corr_bus_pkg::*;
   ();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int ACCUM      = 16;
   localparam int CLK_PERIOD = 4;
   localparam int NROWS      = 8;
   localparam int NPR        = 6;   // Antenna pairs

   // One row per frame
   int row_len   [NROWS] = '{20, 33, 1, 1, 57, 12, 2, 40};  // sums_i
   bit row_gated [NROWS] = '{0, 1, 0, 1, 1, 0, 1, 1};       // en_i from LFSR
   bit row_bank  [NROWS] = '{1, 0, 1, 0, 1, 0, 1, 0};       // Active bank after swap

   // Reference antenna pairs
   int ant_a [NPR] = '{0, 0, 0, 1, 1, 2};
   int ant_b [NPR] = '{1, 2, 3, 2, 3, 3};

   logic                 clk_i;
   logic                 rst_i;
   logic                 en_i;
   logic [3:0]           data_i;
   logic [ACCUM-1:0]     sums_i;
   logic                 rd_stb_i;
   logic [ADDR_BITS-1:0] rd_adr_i;
   logic [ACCUM-1:0]     rd_dat_o;
   logic                 rd_ack_o;
   logic                 swap_o;
   logic                 bank_o;

   logic [31:0] lfsr;
   logic [3:0]  prev_smp;     // Model of the quadrature delay
   int          m_re [NPR];   // Model agreement counts
   int          m_im [NPR];
   int          swaps;
   int          val_errs;
   int          proto_errs;

   always #(CLK_PERIOD / 2) clk_i = ~clk_i;

   corr_top #(.ACCUM(ACCUM)) u_dut (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .en_i     (en_i),
      .data_i   (data_i),
      .sums_i   (sums_i),
      .rd_stb_i (rd_stb_i),
      .rd_adr_i (rd_adr_i),
      .rd_dat_o (rd_dat_o),
      .rd_ack_o (rd_ack_o),
      .swap_o   (swap_o),
      .bank_o   (bank_o)
   );

   // ------------------------------------------------------------------------
   //  Stimulus and model
   // ------------------------------------------------------------------------
   // Galois taps for x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic [31:0] n;
      n = s >> 1;
      if (s[0])
         n = n ^ 32'h8020_0003;
      return n;
   endfunction

   task automatic draw_bits(input int n, output logic [3:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);   // One step per bit
         v[i] = lfsr[0];
      end
   endtask

   task automatic model_sample(input logic [3:0] d);
      for (int p = 0; p < NPR; p++) begin
         if (d[ant_a[p]] == d[ant_b[p]])
            m_re[p]++;
         if (prev_smp[ant_a[p]] == d[ant_b[p]])   // Delayed sample of antenna a
            m_im[p]++;
      end
      prev_smp = d;
   endtask

   task automatic run_frame(input int row);
      logic [3:0] d;
      logic [3:0] g;
      int         taken;
      taken = 0;
      for (int p = 0; p < NPR; p++) begin   // New bank starts from zero
         m_re[p] = 0;
         m_im[p] = 0;
      end
      while (taken < row_len[row]) begin
         @(posedge clk_i);
         g = 4'b0001;
         if (row_gated[row])
            draw_bits(1, g);
         draw_bits(4, d);                   // Noise on data_i in gaps too
         sums_i <= ACCUM'(row_len[row]);
         en_i   <= g[0];
         data_i <= d;
         if (g[0]) begin
            model_sample(d);
            taken++;
         end
      end
      @(posedge clk_i);
      en_i <= 1'b0;                          // Hold off while reading back
   endtask

   task automatic wait_swap(input int row);
      bit seen;
      seen = 1'b0;
      for (int i = 0; i < 8 && !seen; i++) begin
         @(negedge clk_i);
         seen = swap_o;
      end
      if (!seen) begin
         $display("No bank swap was seen after the frame of row %0d", row);
         proto_errs++;
      end else begin
         swaps++;
         if (bank_o !== row_bank[row]) begin
            $display("** Error at %0t: bank_o is %0b after swap, expected %0b",
                     $time, bank_o, row_bank[row]);
            val_errs++;
         end
      end
   endtask

   // ------------------------------------------------------------------------
   //  Read-back
   // ------------------------------------------------------------------------
   task automatic read_check(input rd_addr_u a, input logic [ACCUM-1:0] exp,
                             input string what);
      @(posedge clk_i);
      rd_stb_i <= 1'b1;
      rd_adr_i <= a;
      @(posedge clk_i);
      rd_stb_i <= 1'b0;
      @(negedge clk_i);                      // Ack and data settled here
      if (rd_ack_o !== 1'b1) begin
         $display("Read of address %0d was not acknowledged one cycle after its strobe", a);
         proto_errs++;
      end else if (rd_dat_o !== exp) begin
         $display("** Error at %0t: %s read 0x%0h, expected 0x%0h",
                  $time, what, rd_dat_o, exp);
         val_errs++;
      end
   endtask

   task automatic read_status(input logic sel, input logic [ACCUM-1:0] exp,
                              input string what);
      rd_addr_u a;
      a        = '0;
      a.st.stat = 1'b1;
      a.st.sel  = sel;
      read_check(a, exp, what);
   endtask

   task automatic read_all(input int row);
      rd_addr_u         a;
      logic [ACCUM-1:0] exp;
      for (int p = 0; p < 8; p++) begin
         for (int c = 0; c < 2; c++) begin
            a          = '0;
            a.vis.pair = 3'(p);
            a.vis.comp = c[0];
            exp        = '0;                  // Spare pair codes
            if (p < NPR)
               exp = ACCUM'(c ? m_im[p] : m_re[p]);
            read_check(a, exp, $sformatf("row %0d pair %0d %s", row, p,
                                         c ? "imag" : "real"));
         end
      end
      read_status(STAT_BANK, ACCUM'(row_bank[row]), "STAT_BANK");
      read_status(STAT_FRAMES, ACCUM'(swaps), "STAT_FRAMES");
   endtask

   // ------------------------------------------------------------------------
   //  Main sequence
   // ------------------------------------------------------------------------
   initial begin
      clk_i      = 1'b0;
      rst_i      = 1'b1;
      en_i       = 1'b0;
      data_i     = '0;
      sums_i     = ACCUM'(row_len[0]);
      rd_stb_i   = 1'b0;
      rd_adr_i   = '0;
      lfsr       = 32'hd99b_6e65;
      prev_smp   = '0;                        // Matches the cleared delay line
      swaps      = 0;
      val_errs   = 0;
      proto_errs = 0;
      repeat (3) @(posedge clk_i);
      rst_i <= 1'b0;
      @(negedge clk_i);
      if (bank_o !== 1'b0 || swap_o !== 1'b0) begin
         $display("** Error at %0t: bank_o %0b swap_o %0b after reset, expected 0 0",
                  $time, bank_o, swap_o);
         val_errs++;
      end
      read_status(STAT_FRAMES, '0, "STAT_FRAMES after reset");
      read_status(STAT_BANK, '0, "STAT_BANK after reset");
      for (int r = 0; r < NROWS; r++) begin
         run_frame(r);
         wait_swap(r);
         read_all(r);
      end
      $display("Done: %0d value errors, %0d protocol errors, %0d assertion failures",
               val_errs, proto_errs, u_dut.u_chk.fail_cnt);
      if (val_errs + proto_errs + u_dut.u_chk.fail_cnt == 0)
         $display("TESTBENCH PASSED");
      else
         $display("TESTBENCH FAILED");
      $finish;
   end

   // Watchdog sized from the frame table
   initial begin
      int total;
      total = 0;
      foreach (row_len[i])
         total += row_len[i];
      #((total * 4 + 1000) * CLK_PERIOD);
      $display("Timeout, the run did not finish within %0d cycles", total * 4 + 1000);
      $display("TESTBENCH FAILED");
      $finish;
   end

endmodule : corr_top_tb

`default_nettype wire

// ==== all.f ====
verilog/corr_data_pkg.sv
verilog/corr_bus_pkg.sv
verilog/sign_hilbert.sv
verilog/frame_counter.sv
verilog/bank_switch_fsm.sv
verilog/vis_accumulator.sv
verilog/vis_read_port.sv
verilog/corr_top.sv
tests/corr_top_checker.sv
tests/corr_top_tb.sv
